// ==== verilog/bpu_config.svh ====
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// pc value loaded on reset
`define BPU_RESET_VECTOR 32'h8000_0000

// sequential pc increment for a 32-bit instruction
`define BPU_INSTR_STEP 32'd4

`endif

// ==== verilog/bpu_pkg.sv ====
package bpu_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // branch unit operation
  typedef logic [3:0] bpu_op_t;

  // system operation
  typedef logic [1:0] csr_op_t;

  localparam bpu_op_t BPU_OP_NONE = 4'd0;
  localparam bpu_op_t BPU_OP_BEQ  = 4'd1;
  localparam bpu_op_t BPU_OP_BNE  = 4'd2;
  localparam bpu_op_t BPU_OP_BLT  = 4'd3;
  localparam bpu_op_t BPU_OP_BGE  = 4'd4;
  localparam bpu_op_t BPU_OP_BLTU = 4'd5;
  localparam bpu_op_t BPU_OP_BGEU = 4'd6;
  localparam bpu_op_t BPU_OP_JAL  = 4'd7;
  localparam bpu_op_t BPU_OP_JALR = 4'd8;

  localparam csr_op_t CSR_OP_NONE  = 2'd0;
  localparam csr_op_t CSR_OP_ECALL = 2'd1;
  localparam csr_op_t CSR_OP_MRET  = 2'd2;

endpackage

// ==== verilog/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode import bpu_pkg::*; (
  input  word_t    instr_i,

  output bpu_op_t  bpu_op_o,
  output csr_op_t  csr_op_o,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  output reg_idx_t rd_o,
  output word_t    imm_o,
  output logic     link_we_o
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [11:0] F12_ECALL = 12'h000;
  localparam logic [11:0] F12_MRET  = 12'h302;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign funct12 = instr_i[31:20];

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  always_comb begin
    bpu_op_o = BPU_OP_NONE;
    csr_op_o = CSR_OP_NONE;
    imm_o    = '0;
    case (opcode)
      OPC_BRANCH: begin
        imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        case (funct3)
          3'b000:  bpu_op_o = BPU_OP_BEQ;
          3'b001:  bpu_op_o = BPU_OP_BNE;
          3'b100:  bpu_op_o = BPU_OP_BLT;
          3'b101:  bpu_op_o = BPU_OP_BGE;
          3'b110:  bpu_op_o = BPU_OP_BLTU;
          3'b111:  bpu_op_o = BPU_OP_BGEU;
          default: bpu_op_o = BPU_OP_NONE;
        endcase
      end
      OPC_JAL: begin
        imm_o    = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
        bpu_op_o = BPU_OP_JAL;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          imm_o    = {{21{instr_i[31]}}, instr_i[30:20]};
          bpu_op_o = BPU_OP_JALR;
        end
      end
      OPC_SYSTEM: begin
        // only the fully zero rs1/funct3/rd forms are accepted
        if (funct3 == 3'b000 && rs1_o == '0 && rd_o == '0) begin
          if (funct12 == F12_ECALL) begin
            csr_op_o = CSR_OP_ECALL;
          end else if (funct12 == F12_MRET) begin
            csr_op_o = CSR_OP_MRET;
          end
        end
      end
      default: begin
        bpu_op_o = BPU_OP_NONE;
      end
    endcase
  end

  // jumps write the link address unless rd is x0
  assign link_we_o = ((bpu_op_o == BPU_OP_JAL) || (bpu_op_o == BPU_OP_JALR)) && (rd_o != '0);

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import bpu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    rdata1_o,
  output word_t    rdata2_o,

  input  logic     link_we_i,
  input  reg_idx_t rd_i,
  input  word_t    link_data_i,

  input  logic     load_we_i,
  input  reg_idx_t load_addr_i,
  input  word_t    load_data_i
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (load_we_i) begin
      // load port wins over the link write
      if (load_addr_i != '0) begin
        regs[load_addr_i] <= load_data_i;
      end
    end else if (link_we_i && (rd_i != '0)) begin
      regs[rd_i] <= link_data_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== verilog/csr_trap.sv ====
`timescale 1ns/10ps

module csr_trap import bpu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,

  input  logic    instr_valid_i,
  input  csr_op_t csr_op_i,
  input  word_t   pc_i,

  input  logic    mtvec_we_i,
  input  word_t   mtvec_wdata_i,

  output word_t   csr_rdata_o
);

  word_t mepc_q;
  word_t mtvec_q;
  logic  trap_take;

  assign trap_take = instr_valid_i && (csr_op_i == CSR_OP_ECALL);

  // mepc captures the pc of the ecall itself
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mepc_q <= '0;
    end else if (trap_take) begin
      mepc_q <= pc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtvec_q <= '0;
    end else if (mtvec_we_i) begin
      mtvec_q <= mtvec_wdata_i;
    end
  end

  // ecall jumps to the trap vector, mret and everything else see mepc
  always_comb begin
    case (csr_op_i)
      CSR_OP_ECALL: csr_rdata_o = mtvec_q;
      default:      csr_rdata_o = mepc_q;
    endcase
  end

endmodule

// ==== verilog/branch_log.sv ====
`timescale 1ns/10ps
`include "bpu_config.svh"

module branch_log import bpu_pkg::*; (
  input  bpu_op_t bpu_op_i,
  input  csr_op_t csr_op_i,

  input  word_t   pc_i,
  input  word_t   imm_i,
  input  word_t   rdata1_i,
  input  word_t   rdata2_i,
  input  word_t   csr_rdata_i,

  output logic    branch_en_o,
  output word_t   dnpc_o
);

  logic  equal;
  logic  signed_less_than;
  logic  unsigned_less_than;
  word_t jalr_target;

  subtract u_subtract (
    .rdata1_i             (rdata1_i),
    .rdata2_i             (rdata2_i),
    .equal_o              (equal),
    .signed_less_than_o   (signed_less_than),
    .unsigned_less_than_o (unsigned_less_than)
  );

  always_comb begin
    case (bpu_op_i)
      BPU_OP_BEQ:  branch_en_o = equal;
      BPU_OP_BNE:  branch_en_o = !equal;
      BPU_OP_BLT:  branch_en_o = signed_less_than;
      BPU_OP_BGE:  branch_en_o = !signed_less_than;
      BPU_OP_BLTU: branch_en_o = unsigned_less_than;
      BPU_OP_BGEU: branch_en_o = !unsigned_less_than;
      BPU_OP_JAL:  branch_en_o = 1'b1;
      BPU_OP_JALR: branch_en_o = 1'b1;
      default:     branch_en_o = (csr_op_i == CSR_OP_ECALL) || (csr_op_i == CSR_OP_MRET);
    endcase
  end

  // jalr target has bit 0 forced low
  assign jalr_target = (rdata1_i + imm_i) & ~32'h1;

  always_comb begin
    if (!branch_en_o) begin
      dnpc_o = pc_i + `BPU_INSTR_STEP;
    end else if (csr_op_i != CSR_OP_NONE) begin
      dnpc_o = csr_rdata_i;
    end else if (bpu_op_i == BPU_OP_JALR) begin
      dnpc_o = jalr_target;
    end else begin
      dnpc_o = pc_i + imm_i;
    end
  end

endmodule

module subtract import bpu_pkg::*; (
  input  word_t rdata1_i,
  input  word_t rdata2_i,

  output logic  equal_o,
  output logic  signed_less_than_o,
  output logic  unsigned_less_than_o
);

  logic  cout;
  word_t result;
  logic  overflow;

  // a - b as a + ~b + 1, carry out low means borrow
  assign {cout, result} = {1'b0, rdata1_i} + {1'b0, ~rdata2_i} + 33'd1;

  assign overflow = (rdata1_i[31] & ~rdata2_i[31] & ~result[31]) |
                    (~rdata1_i[31] & rdata2_i[31] & result[31]);

  assign equal_o              = (result == '0);
  assign signed_less_than_o   = result[31] ^ overflow;
  assign unsigned_less_than_o = ~cout;

endmodule

// ==== verilog/pc_seq.sv ====
`timescale 1ns/10ps
`include "bpu_config.svh"

module pc_seq import bpu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  instr_valid_i,
  input  logic  branch_en_i,
  input  word_t dnpc_i,

  output word_t pc_o,
  output logic  branch_taken_o,
  output word_t retired_o
);

  word_t pc_q;
  logic  taken_q;
  word_t retired_q;

  // all state moves only on accepted instructions
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q      <= `BPU_RESET_VECTOR;
      taken_q   <= 1'b0;
      retired_q <= '0;
    end else if (instr_valid_i) begin
      pc_q      <= dnpc_i;
      taken_q   <= branch_en_i;
      retired_q <= retired_q + 32'd1;
    end
  end

  assign pc_o           = pc_q;
  assign branch_taken_o = taken_q;
  assign retired_o      = retired_q;

endmodule

// ==== verilog/branch_ctrl_top.sv ====
`timescale 1ns/10ps
`include "bpu_config.svh"

module branch_ctrl_top import bpu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     instr_valid_i,
  input  word_t    instr_i,

  input  logic     reg_we_i,
  input  reg_idx_t reg_waddr_i,
  input  word_t    reg_wdata_i,

  input  logic     mtvec_we_i,
  input  word_t    mtvec_wdata_i,

  output word_t    pc_o,
  output logic     branch_taken_o,
  output word_t    retired_o
);

  bpu_op_t  bpu_op;
  csr_op_t  csr_op;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  logic     link_we;
  word_t    link_data;
  word_t    rdata1;
  word_t    rdata2;
  word_t    csr_rdata;
  logic     branch_en;
  word_t    dnpc;

  // return address for jal and jalr
  assign link_data = pc_o + `BPU_INSTR_STEP;

  instr_decode u_instr_decode (
    .instr_i   (instr_i),
    .bpu_op_o  (bpu_op),
    .csr_op_o  (csr_op),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rd_o      (rd),
    .imm_o     (imm),
    .link_we_o (link_we)
  );

  // link write only happens on an accepted instruction
  reg_file u_reg_file (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rdata1_o    (rdata1),
    .rdata2_o    (rdata2),
    .link_we_i   (link_we & instr_valid_i),
    .rd_i        (rd),
    .link_data_i (link_data),
    .load_we_i   (reg_we_i),
    .load_addr_i (reg_waddr_i),
    .load_data_i (reg_wdata_i)
  );

  csr_trap u_csr_trap (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .csr_op_i      (csr_op),
    .pc_i          (pc_o),
    .mtvec_we_i    (mtvec_we_i),
    .mtvec_wdata_i (mtvec_wdata_i),
    .csr_rdata_o   (csr_rdata)
  );

  branch_log u_branch_log (
    .bpu_op_i    (bpu_op),
    .csr_op_i    (csr_op),
    .pc_i        (pc_o),
    .imm_i       (imm),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .csr_rdata_i (csr_rdata),
    .branch_en_o (branch_en),
    .dnpc_o      (dnpc)
  );

  pc_seq u_pc_seq (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .branch_en_i    (branch_en),
    .dnpc_i         (dnpc),
    .pc_o           (pc_o),
    .branch_taken_o (branch_taken_o),
    .retired_o      (retired_o)
  );

endmodule

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  // free running clock, starts low
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PERIOD / 2);
    clk_o = ~clk_o;
  end

endmodule

// ==== testbench/branch_ctrl_asserts.sv ====
`timescale 1ns/10ps

module branch_ctrl_asserts import bpu_pkg::*; (
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  instr_valid_i,
  input word_t pc_i,
  input logic  branch_taken_i
);

  int unsigned fail_cnt = 0;

  // idle cycles leave the pc alone
  pc_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !instr_valid_i |=> $stable(pc_i))
    else begin
      $error("pc moved in a cycle without a valid instruction");
      fail_cnt++;
    end

  pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_i[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      fail_cnt++;
    end

  taken_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !branch_taken_i)
    else begin
      $error("taken flag set right after reset");
      fail_cnt++;
    end

endmodule

bind branch_ctrl_top branch_ctrl_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .instr_valid_i  (instr_valid_i),
  .pc_i           (pc_o),
  .branch_taken_i (branch_taken_o)
);

// ==== testbench/branch_ctrl_tb.sv ====
`timescale 1ns/10ps
`include "bpu_config.svh"

module branch_ctrl_tb import bpu_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int MAX_ENTRIES = 64;

  // kinds 0 to 5 are the conditional branches
  localparam int K_BEQ   = 0;
  localparam int K_BNE   = 1;
  localparam int K_BLT   = 2;
  localparam int K_BGE   = 3;
  localparam int K_BLTU  = 4;
  localparam int K_BGEU  = 5;
  localparam int K_JAL   = 6;
  localparam int K_JALR  = 7;
  localparam int K_ECALL = 8;
  localparam int K_MRET  = 9;
  localparam int K_OTHER = 10;
  localparam int K_IDLE  = 11;
  localparam int K_MTVEC = 12;

  logic     clk;
  logic     rst_n;
  logic     instr_valid;
  word_t    instr;
  logic     reg_we;
  reg_idx_t reg_waddr;
  word_t    reg_wdata;
  logic     mtvec_we;
  word_t    mtvec_wdata;
  word_t    pc;
  logic     taken;
  word_t    retired;

  string    t_name [MAX_ENTRIES];
  int       t_kind [MAX_ENTRIES];
  word_t    t_instr [MAX_ENTRIES];
  reg_idx_t t_rd [MAX_ENTRIES];
  reg_idx_t t_rs1 [MAX_ENTRIES];
  word_t    t_imm [MAX_ENTRIES];
  word_t    t_v1 [MAX_ENTRIES];
  word_t    t_v2 [MAX_ENTRIES];
  bit       t_preload [MAX_ENTRIES];
  bit       t_check [MAX_ENTRIES];
  int       n_entries = 0;

  // reference model of the architectural state
  word_t m_regs [32];
  word_t m_pc;
  word_t m_mepc;
  word_t m_mtvec;
  word_t m_retired;
  bit    m_taken;

  logic [31:0] lfsr_state;
  bit          table_ready = 1'b0;
  int          limit_cycles = 0;
  bit          entry_failed;
  int          n_pass = 0;
  int          n_fail = 0;

  tb_clkgen #(.PERIOD(CLK_PERIOD)) u_clkgen (
    .clk_o (clk)
  );

  branch_ctrl_top uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .reg_we_i       (reg_we),
    .reg_waddr_i    (reg_waddr),
    .reg_wdata_i    (reg_wdata),
    .mtvec_we_i     (mtvec_we),
    .mtvec_wdata_i  (mtvec_wdata),
    .pc_o           (pc),
    .branch_taken_o (taken),
    .retired_o      (retired)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic word_t random_word();
    word_t w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [2:0] funct3_of(input int kind);
    case (kind)
      K_BEQ:   return 3'b000;
      K_BNE:   return 3'b001;
      K_BLT:   return 3'b100;
      K_BGE:   return 3'b101;
      K_BLTU:  return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic string op_name(input int kind);
    case (kind)
      K_BEQ:   return "beq";
      K_BNE:   return "bne";
      K_BLT:   return "blt";
      K_BGE:   return "bge";
      K_BLTU:  return "bltu";
      default: return "bgeu";
    endcase
  endfunction

  // RV32I compare of rs1 against rs2
  function automatic logic branch_cond(input int kind, input word_t a, input word_t b);
    case (kind)
      K_BEQ:   return a == b;
      K_BNE:   return a != b;
      K_BLT:   return $signed(a) < $signed(b);
      K_BGE:   return $signed(a) >= $signed(b);
      K_BLTU:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // B-type with rs1 = x1 and rs2 = x2
  function automatic word_t branch_word(input logic [2:0] f3, input word_t imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t jal_word(input reg_idx_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t jalr_word(input reg_idx_t rd, input reg_idx_t rs1, input word_t imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
  endfunction

  task automatic add_entry(input string name, input int kind, input word_t word,
                           input reg_idx_t rd, input reg_idx_t rs1, input word_t imm,
                           input word_t v1, input word_t v2, input bit preload,
                           input bit check);
    t_name[n_entries]    = name;
    t_kind[n_entries]    = kind;
    t_instr[n_entries]   = word;
    t_rd[n_entries]      = rd;
    t_rs1[n_entries]     = rs1;
    t_imm[n_entries]     = imm;
    t_v1[n_entries]      = v1;
    t_v2[n_entries]      = v2;
    t_preload[n_entries] = preload;
    t_check[n_entries]   = check;
    n_entries++;
  endtask

  task automatic build_table();
    word_t a;
    word_t b;
    word_t imm;
    add_entry("reset_idle", K_IDLE, '0, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
    for (int k = K_BEQ; k <= K_BGEU; k++) begin
      for (int p = 0; p < 7; p++) begin
        a = random_word();
        b = random_word();
        case (p)
          2: b = a;
          3: {a, b} = {32'h8000_0000, 32'h7fff_ffff};
          4: {a, b} = {32'h7fff_ffff, 32'h8000_0000};
          5: {a, b} = {32'h0000_0000, 32'hffff_ffff};
          6: {a, b} = {32'hffff_ffff, 32'h0000_0000};
          default: ;
        endcase
        imm = p[0] ? 32'hffff_fff0 : 32'd24;
        add_entry($sformatf("%s_%0d", op_name(k), p), k, branch_word(funct3_of(k), imm),
                  5'd0, 5'd1, imm, a, b, 1'b1, 1'b1);
      end
    end
    // funct3 010 has no branch meaning
    add_entry("bad_branch", K_OTHER, branch_word(3'b010, 32'd8), 5'd0, 5'd1, '0,
              32'd5, 32'd5, 1'b1, 1'b1);
    add_entry("addi", K_OTHER, 32'h0010_8093, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
    add_entry("jal_link", K_JAL, jal_word(5'd5, 32'h40), 5'd5, 5'd0, 32'h40,
              '0, '0, 1'b0, 1'b1);
    add_entry("jalr_rb5", K_JALR, jalr_word(5'd0, 5'd5, '0), 5'd0, 5'd5, '0,
              '0, '0, 1'b0, 1'b1);
    add_entry("jal_x0", K_JAL, jal_word(5'd0, 32'hffff_ffe0), 5'd0, 5'd0, 32'hffff_ffe0,
              '0, '0, 1'b0, 1'b1);
    add_entry("jalr_x0_base", K_JALR, jalr_word(5'd0, 5'd0, 32'h100), 5'd0, 5'd0, 32'h100,
              '0, '0, 1'b0, 1'b1);
    add_entry("jalr_bit0", K_JALR, jalr_word(5'd6, 5'd3, '0), 5'd6, 5'd3, '0,
              32'h8000_0201, '0, 1'b1, 1'b1);
    add_entry("jalr_rb6", K_JALR, jalr_word(5'd0, 5'd6, '0), 5'd0, 5'd6, '0,
              '0, '0, 1'b0, 1'b1);
    add_entry("jalr_rd_rs1", K_JALR, jalr_word(5'd7, 5'd7, 32'hffff_fff8), 5'd7, 5'd7,
              32'hffff_fff8, 32'h8000_2000, '0, 1'b1, 1'b1);
    add_entry("jalr_rb7", K_JALR, jalr_word(5'd0, 5'd7, '0), 5'd0, 5'd7, '0,
              '0, '0, 1'b0, 1'b1);
    add_entry("mtvec_load", K_MTVEC, '0, 5'd0, 5'd0, '0, 32'h8000_4000, '0, 1'b0, 1'b0);
    add_entry("idle_hold", K_IDLE, '0, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
    add_entry("ecall", K_ECALL, 32'h0000_0073, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
    add_entry("trap_addi", K_OTHER, 32'h0010_8093, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
    add_entry("mret", K_MRET, 32'h3020_0073, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
    add_entry("idle_end", K_IDLE, '0, 5'd0, 5'd0, '0, '0, '0, 1'b0, 1'b1);
  endtask

  task automatic next_slot();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic load_reg(input reg_idx_t addr, input word_t data);
    reg_we    = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
    next_slot();
    reg_we    = 1'b0;
    if (addr != 5'd0) begin
      m_regs[addr] = data;
    end
  endtask

  task automatic check_value(input string name, input string what, input word_t exp,
                             input word_t act);
    assert (act === exp) else begin
      $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
      entry_failed = 1'b1;
    end
  endtask

  task automatic apply_entry(input int i);
    word_t target;
    target       = '0;
    entry_failed = 1'b0;
    if (t_preload[i]) begin
      load_reg(t_rs1[i], t_v1[i]);
      load_reg(5'd2, t_v2[i]);
    end
    if (t_kind[i] == K_IDLE) begin
      repeat (3) next_slot();
    end else if (t_kind[i] == K_MTVEC) begin
      mtvec_we    = 1'b1;
      mtvec_wdata = t_v1[i];
      m_mtvec     = t_v1[i];
      next_slot();
      mtvec_we    = 1'b0;
    end else begin
      instr_valid = 1'b1;
      instr       = t_instr[i];
      m_taken     = 1'b1;
      case (t_kind[i])
        K_JAL:   target = m_pc + t_imm[i];
        K_JALR:  target = (m_regs[t_rs1[i]] + t_imm[i]) & ~32'h1;
        K_ECALL: begin
          m_mepc = m_pc;
          target = m_mtvec;
        end
        K_MRET:  target = m_mepc;
        K_OTHER: begin
          m_taken = 1'b0;
          target  = m_pc + `BPU_INSTR_STEP;
        end
        default: begin
          m_taken = branch_cond(t_kind[i], m_regs[1], m_regs[2]);
          target  = m_taken ? m_pc + t_imm[i] : m_pc + `BPU_INSTR_STEP;
        end
      endcase
      // target is read before the link write, so rd may equal rs1
      if ((t_kind[i] == K_JAL || t_kind[i] == K_JALR) && t_rd[i] != 5'd0) begin
        m_regs[t_rd[i]] = m_pc + `BPU_INSTR_STEP;
      end
      m_pc      = target;
      m_retired = m_retired + 32'd1;
      next_slot();
      instr_valid = 1'b0;
    end
    if (t_check[i]) begin
      check_value(t_name[i], "pc", m_pc, pc);
      check_value(t_name[i], "taken", {31'b0, m_taken}, {31'b0, taken});
      check_value(t_name[i], "retired", m_retired, retired);
    end
    if (entry_failed) begin
      n_fail++;
    end else begin
      n_pass++;
    end
    $display("%-14s %s", t_name[i], entry_failed ? "fail" : "pass");
  endtask

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    reg_we      = 1'b0;
    reg_waddr   = '0;
    reg_wdata   = '0;
    mtvec_we    = 1'b0;
    mtvec_wdata = '0;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    m_pc       = `BPU_RESET_VECTOR;
    m_mepc     = '0;
    m_mtvec    = '0;
    m_retired  = '0;
    m_taken    = 1'b0;
    lfsr_state = 32'haa13_f4fd;
    build_table();
    // an entry needs at most three cycles, plus reset and some slack
    limit_cycles = 3 * n_entries + 2 + 20;
    table_ready  = 1'b1;
    repeat (2) next_slot();
    rst_n = 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      apply_entry(i);
    end
    $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
             n_entries, n_pass, n_fail, uut.u_asserts.fail_cnt);
    if (n_fail == 0 && uut.u_asserts.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (table_ready);
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/bpu_pkg.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/csr_trap.sv
verilog/branch_log.sv
verilog/pc_seq.sv
verilog/branch_ctrl_top.sv
testbench/tb_clkgen.sv
testbench/branch_ctrl_asserts.sv
testbench/branch_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module branch_ctrl_tb -Mdir obj_dir \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vbranch_ctrl_tb > sim.log 2>&1 ; cat sim.log

! grep -q "Simulation FAILED" sim.log && grep -q "Simulation PASSED" sim.log \
  && echo "run_sim: ok" \
  || { echo "run_sim: failure found in sim.log"; exit 1; }
